// File: verilog/pipe_pkg.sv
// Pipeline stage field types
`default_nettype none

package pipe_pkg;

  //////////////////////////////
  // Register file
  //////////////////////////////

  // Architectural register index width
  localparam int RF_ADDR_W = 5;

  // Register index as carried by each stage
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  // Read ports on the ID stage
  localparam int RF_READ_PORTS = 2;

  // Port positions inside the read enable vector
  localparam int PORT_A = 0;
  localparam int PORT_B = 1;

  // One read enable per ID read port
  typedef logic [RF_READ_PORTS-1:0] rf_re_t;

  //////////////////////////////
  // CSR space
  //////////////////////////////

  // Full CSR address width
  localparam int CSR_ADDR_W = 12;

  // CSR address carried by EX and WB
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

endpackage

`default_nettype wire

// File: verilog/byp_pkg.sv
// Bypass control result types
`default_nettype none

package byp_pkg;

  //////////////////////////////
  // Operand forwarding
  //////////////////////////////

  // Width of the operand mux select
  localparam int FW_SEL_W = 2;

  // Operand source for the ID read ports
  // Register file by default
  typedef enum logic [FW_SEL_W-1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  //////////////////////////////
  // Jump register path
  //////////////////////////////

  // Width of the jump target mux select
  localparam int JALR_SEL_W = 1;

  // Jump target source
  // Only WB results are forwarded here
  typedef enum logic [JALR_SEL_W-1:0] {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_fw_sel_e;

endpackage

`default_nettype wire

// File: verilog/stage_qualify.sv
// Stage valid qualification
`timescale 1ns/1ps
`default_nettype none

module stage_qualify (
  // Assertion sampling only
  input  wire  clk_i,
  input  wire  rst_i,

  // ID stage
  input  wire  id_valid_i,
  input  wire  id_jalr_i,
  input  wire  id_mret_i,
  input  wire  id_tbljmp_i,
  input  wire  id_fetch_err_i,
  input  wire  id_trigger_i,

  // EX stage
  input  wire  ex_valid_i,
  input  wire  ex_rf_we_i,
  input  wire  ex_lsu_en_i,
  input  wire  ex_wfi_i,

  // WB stage
  input  wire  wb_valid_i,
  input  wire  wb_rf_we_i,
  input  wire  wb_lsu_en_i,

  // Qualified levels
  output logic ex_rf_we_q_o,
  output logic wb_rf_we_q_o,
  output logic ex_lsu_q_o,
  output logic wb_lsu_q_o,
  output logic id_jalr_q_o,
  output logic id_csr_impl_rd_q_o,

  // ID side control
  output logic sleep_stall_o,
  output logic deassert_we_o
);

  //////////////////////////////
  // EX and WB writers
  //////////////////////////////

  // Write enables count only for a live instruction
  assign ex_rf_we_q_o = ex_rf_we_i && ex_valid_i;
  assign wb_rf_we_q_o = wb_rf_we_i && wb_valid_i;

  // Loads and stores in flight
  assign ex_lsu_q_o = ex_lsu_en_i && ex_valid_i;
  assign wb_lsu_q_o = wb_lsu_en_i && wb_valid_i;

  //////////////////////////////
  // ID flags
  //////////////////////////////

  // Conservative flags
  // Deassert is ignored here so a killed instruction may still stall a cycle
  assign id_jalr_q_o = id_jalr_i && id_valid_i;

  // mret reads mepc and mcause, table jump reads jvt
  assign id_csr_impl_rd_q_o = (id_mret_i || id_tbljmp_i) && id_valid_i;

  // Hold ID while a WFI sits in EX
  assign sleep_stall_o = ex_wfi_i && ex_valid_i;

  // Faulting fetch or trigger hit turns the ID instruction into a bubble
  assign deassert_we_o = id_fetch_err_i || id_trigger_i;

  // Bubble control must be known out of reset
  a_deassert_known : assert property (@(posedge clk_i) disable iff (rst_i)
    !$isunknown(deassert_we_o))
    else $error("deassert_we_o unknown from fetch error or trigger");

endmodule

`default_nettype wire

// File: verilog/rf_hazard.sv
// Register file hazard and forwarding
`timescale 1ns/1ps
`default_nettype none

module rf_hazard (
  // Assertion sampling only
  input  wire                    clk_i,
  input  wire                    rst_i,

  // ID read side
  input  wire pipe_pkg::rf_re_t  id_rf_re_i,
  input  wire pipe_pkg::rf_addr_t id_raddr_a_i,
  input  wire pipe_pkg::rf_addr_t id_raddr_b_i,

  // Write addresses of the later stages
  input  wire pipe_pkg::rf_addr_t ex_waddr_i,
  input  wire pipe_pkg::rf_addr_t wb_waddr_i,
  input  wire                    wb_ready_i,

  // Valid qualified levels
  input  wire                    ex_rf_we_q_i,
  input  wire                    wb_rf_we_q_i,
  input  wire                    ex_lsu_q_i,
  input  wire                    wb_lsu_q_i,
  input  wire                    id_jalr_q_i,

  // Mux selects
  output byp_pkg::fw_sel_e       op_a_fw_sel_o,
  output byp_pkg::fw_sel_e       op_b_fw_sel_o,
  output byp_pkg::jalr_fw_sel_e  jalr_fw_sel_o,

  // Stalls
  output logic                   load_stall_o,
  output logic                   jalr_stall_o
);

  // Read addresses indexed by port
  pipe_pkg::rf_addr_t raddr [pipe_pkg::RF_READ_PORTS];

  // Per port address hits, not yet qualified with the stage write enable
  pipe_pkg::rf_re_t   ex_match;
  pipe_pkg::rf_re_t   wb_match;

  // Resulting operand selects
  byp_pkg::fw_sel_e   fw_sel [pipe_pkg::RF_READ_PORTS];

  // Jump target hits on port A
  logic               ex_jalr_match;
  logic               wb_jalr_match;

  assign raddr[pipe_pkg::PORT_A] = id_raddr_a_i;
  assign raddr[pipe_pkg::PORT_B] = id_raddr_b_i;

  //////////////////////////////
  // Address matching
  //////////////////////////////

  for (genvar i = 0; i < pipe_pkg::RF_READ_PORTS; i++) begin : gen_port
    // x0 never forwards
    assign ex_match[i] = id_rf_re_i[i] && (|raddr[i]) && (raddr[i] == ex_waddr_i);
    assign wb_match[i] = id_rf_re_i[i] && (|raddr[i]) && (raddr[i] == wb_waddr_i);

    // Youngest result wins
    // EX over WB over register file
    assign fw_sel[i] = (ex_rf_we_q_i && ex_match[i]) ? byp_pkg::SEL_FW_EX :
                       (wb_rf_we_q_i && wb_match[i]) ? byp_pkg::SEL_FW_WB :
                                                       byp_pkg::SEL_REGFILE;
  end

  assign op_a_fw_sel_o = fw_sel[pipe_pkg::PORT_A];
  assign op_b_fw_sel_o = fw_sel[pipe_pkg::PORT_B];

  // Jump register reads rs1 on port A
  // Read enable is implied by the jump so it is left out
  assign ex_jalr_match = (|id_raddr_a_i) && (id_raddr_a_i == ex_waddr_i);
  assign wb_jalr_match = (|id_raddr_a_i) && (id_raddr_a_i == wb_waddr_i);

  //////////////////////////////
  // Stalls and jump select
  //////////////////////////////

  // Load data arrives too late for the EX bypass
  // WB match matters only while WB waits on the bus
  assign load_stall_o = (ex_lsu_q_i && ex_rf_we_q_i && (|ex_match)) ||
                        (!wb_ready_i && wb_rf_we_q_i && (|wb_match));

  // Jump target forwards only ALU results from WB
  // Any EX writer or a WB load on rs1 holds the jump
  assign jalr_stall_o = id_jalr_q_i &&
                        ((ex_rf_we_q_i && ex_jalr_match) ||
                         (wb_rf_we_q_i && wb_lsu_q_i && wb_jalr_match));

  // Don't care while stalled or when no jump is in ID
  assign jalr_fw_sel_o = (wb_rf_we_q_i && wb_jalr_match) ? byp_pkg::SELJ_FW_WB :
                                                           byp_pkg::SELJ_REGFILE;

  // A stalled jump must come from a jump in ID
  a_jalr_stall_src : assert property (@(posedge clk_i) disable iff (rst_i)
    jalr_stall_o |-> id_jalr_q_i)
    else $error("jalr_stall_o without a jump register in ID");

  // x0 reads always come from the register file
  a_zero_a_no_fw : assert property (@(posedge clk_i) disable iff (rst_i)
    (id_raddr_a_i == '0) |-> (op_a_fw_sel_o == byp_pkg::SEL_REGFILE) &&
                             (jalr_fw_sel_o == byp_pkg::SELJ_REGFILE))
    else $error("forward select on x0 for operand A");

  a_zero_b_no_fw : assert property (@(posedge clk_i) disable iff (rst_i)
    (id_raddr_b_i == '0) |-> (op_b_fw_sel_o == byp_pkg::SEL_REGFILE))
    else $error("forward select on x0 for operand B");

endmodule

`default_nettype wire

// File: verilog/csr_hazard.sv
// CSR hazard detection
`timescale 1ns/1ps
`default_nettype none

module csr_hazard (
  // Assertion sampling only
  input  wire                      clk_i,
  input  wire                      rst_i,

  // Implicit CSR read in ID, already valid qualified
  input  wire                      id_csr_impl_rd_q_i,

  // EX stage CSR fields
  input  wire                      ex_valid_i,
  input  wire                      ex_csr_en_i,
  input  wire                      ex_mret_i,
  input  wire                      ex_csr_impl_wr_i,
  input  wire                      ex_csr_impl_re_i,
  input  wire                      ex_csr_expl_re_i,
  input  wire pipe_pkg::csr_addr_t ex_csr_raddr_i,

  // WB stage CSR fields
  input  wire                      wb_valid_i,
  input  wire                      wb_csr_en_i,
  input  wire                      wb_mret_i,
  input  wire                      wb_csr_impl_wr_i,
  input  wire                      wb_csr_expl_we_i,
  input  wire pipe_pkg::csr_addr_t wb_csr_waddr_i,

  // Stalls
  output logic                     csr_stall_id_o,
  output logic                     csr_stall_ex_o
);

  // Explicit CSR instruction present
  logic ex_csr_q;
  logic wb_csr_q;

  // Implicit writes (mret or CSR side effects)
  logic ex_impl_wr;
  logic wb_impl_wr;

  // Any CSR write, implicit or explicit
  logic ex_csr_wr;
  logic wb_csr_wr;

  // Read and write flags from the CSR decode
  logic ex_impl_rd;
  logic ex_expl_rd;
  logic wb_expl_wr;
  logic expl_raw_hz;

  //////////////////////////////
  // Write detection
  //////////////////////////////

  assign ex_csr_q = ex_csr_en_i && ex_valid_i;
  assign wb_csr_q = wb_csr_en_i && wb_valid_i;

  // mret updates mstatus, some CSR ops write a second CSR
  assign ex_impl_wr = ex_valid_i && (ex_mret_i || (ex_csr_en_i && ex_csr_impl_wr_i));
  assign wb_impl_wr = wb_valid_i && (wb_mret_i || (wb_csr_en_i && wb_csr_impl_wr_i));

  assign ex_csr_wr = ex_csr_q || ex_impl_wr;
  assign wb_csr_wr = wb_csr_q || wb_impl_wr;

  // Decode flags mean something only on a live CSR instruction
  assign ex_impl_rd = ex_csr_q && ex_csr_impl_re_i;
  assign ex_expl_rd = ex_csr_q && ex_csr_expl_re_i;
  assign wb_expl_wr = wb_csr_q && wb_csr_expl_we_i;

  // Exact RAW on the same CSR
  assign expl_raw_hz = ex_expl_rd && wb_expl_wr && (ex_csr_raddr_i == wb_csr_waddr_i);

  //////////////////////////////
  // Stalls
  //////////////////////////////

  // Implicit read in ID
  // Conservative on any write further down
  assign csr_stall_id_o = id_csr_impl_rd_q_i && (ex_csr_wr || wb_csr_wr);

  // EX waits for WB on
  // implicit read against any WB write
  // explicit CSR against an implicit WB write
  // explicit read against an explicit write to the same address
  assign csr_stall_ex_o = (ex_impl_rd && wb_csr_wr) ||
                          (ex_csr_q && wb_impl_wr) ||
                          expl_raw_hz;

  // An ID stall needs a writer somewhere behind it
  a_id_stall_needs_writer : assert property (@(posedge clk_i) disable iff (rst_i)
    csr_stall_id_o |-> (ex_valid_i || wb_valid_i))
    else $error("csr_stall_id_o with EX and WB both empty");

endmodule

`default_nettype wire

// File: verilog/hazard_bypass_top.sv
// Hazard and bypass control top
`timescale 1ns/1ps
`default_nettype none

module hazard_bypass_top (
  input  wire                      clk_i,
  input  wire                      rst_i,

  // ID stage
  input  wire                      id_valid_i,
  input  wire pipe_pkg::rf_re_t    id_rf_re_i,
  input  wire pipe_pkg::rf_addr_t  id_raddr_a_i,
  input  wire pipe_pkg::rf_addr_t  id_raddr_b_i,
  input  wire                      id_jalr_i,
  input  wire                      id_mret_i,
  input  wire                      id_tbljmp_i,
  input  wire                      id_fetch_err_i,
  input  wire                      id_trigger_i,

  // EX stage
  input  wire                      ex_valid_i,
  input  wire                      ex_rf_we_i,
  input  wire pipe_pkg::rf_addr_t  ex_waddr_i,
  input  wire                      ex_lsu_en_i,
  input  wire                      ex_csr_en_i,
  input  wire                      ex_mret_i,
  input  wire                      ex_wfi_i,
  input  wire                      ex_csr_impl_wr_i,
  input  wire                      ex_csr_impl_re_i,
  input  wire                      ex_csr_expl_re_i,
  input  wire pipe_pkg::csr_addr_t ex_csr_raddr_i,

  // WB stage
  input  wire                      wb_valid_i,
  input  wire                      wb_ready_i,
  input  wire                      wb_rf_we_i,
  input  wire pipe_pkg::rf_addr_t  wb_waddr_i,
  input  wire                      wb_lsu_en_i,
  input  wire                      wb_csr_en_i,
  input  wire                      wb_mret_i,
  input  wire                      wb_csr_impl_wr_i,
  input  wire                      wb_csr_expl_we_i,
  input  wire pipe_pkg::csr_addr_t wb_csr_waddr_i,

  // Bypass control
  output byp_pkg::fw_sel_e         op_a_fw_sel_o,
  output byp_pkg::fw_sel_e         op_b_fw_sel_o,
  output byp_pkg::jalr_fw_sel_e    jalr_fw_sel_o,
  output logic                     load_stall_o,
  output logic                     jalr_stall_o,
  output logic                     csr_stall_id_o,
  output logic                     csr_stall_ex_o,
  output logic                     sleep_stall_o,
  output logic                     deassert_we_o
);

  // Valid qualified levels from stage_qualify
  logic ex_rf_we_q;
  logic wb_rf_we_q;
  logic ex_lsu_q;
  logic wb_lsu_q;
  logic id_jalr_q;
  logic id_csr_impl_rd_q;

  stage_qualify stage_qualify_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .id_valid_i         (id_valid_i),
    .id_jalr_i          (id_jalr_i),
    .id_mret_i          (id_mret_i),
    .id_tbljmp_i        (id_tbljmp_i),
    .id_fetch_err_i     (id_fetch_err_i),
    .id_trigger_i       (id_trigger_i),
    .ex_valid_i         (ex_valid_i),
    .ex_rf_we_i         (ex_rf_we_i),
    .ex_lsu_en_i        (ex_lsu_en_i),
    .ex_wfi_i           (ex_wfi_i),
    .wb_valid_i         (wb_valid_i),
    .wb_rf_we_i         (wb_rf_we_i),
    .wb_lsu_en_i        (wb_lsu_en_i),
    .ex_rf_we_q_o       (ex_rf_we_q),
    .wb_rf_we_q_o       (wb_rf_we_q),
    .ex_lsu_q_o         (ex_lsu_q),
    .wb_lsu_q_o         (wb_lsu_q),
    .id_jalr_q_o        (id_jalr_q),
    .id_csr_impl_rd_q_o (id_csr_impl_rd_q),
    .sleep_stall_o      (sleep_stall_o),
    .deassert_we_o      (deassert_we_o)
  );

  rf_hazard rf_hazard_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .id_rf_re_i    (id_rf_re_i),
    .id_raddr_a_i  (id_raddr_a_i),
    .id_raddr_b_i  (id_raddr_b_i),
    .ex_waddr_i    (ex_waddr_i),
    .wb_waddr_i    (wb_waddr_i),
    .wb_ready_i    (wb_ready_i),
    .ex_rf_we_q_i  (ex_rf_we_q),
    .wb_rf_we_q_i  (wb_rf_we_q),
    .ex_lsu_q_i    (ex_lsu_q),
    .wb_lsu_q_i    (wb_lsu_q),
    .id_jalr_q_i   (id_jalr_q),
    .op_a_fw_sel_o (op_a_fw_sel_o),
    .op_b_fw_sel_o (op_b_fw_sel_o),
    .jalr_fw_sel_o (jalr_fw_sel_o),
    .load_stall_o  (load_stall_o),
    .jalr_stall_o  (jalr_stall_o)
  );

  // CSR fields go in raw and are qualified inside
  csr_hazard csr_hazard_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .id_csr_impl_rd_q_i (id_csr_impl_rd_q),
    .ex_valid_i         (ex_valid_i),
    .ex_csr_en_i        (ex_csr_en_i),
    .ex_mret_i          (ex_mret_i),
    .ex_csr_impl_wr_i   (ex_csr_impl_wr_i),
    .ex_csr_impl_re_i   (ex_csr_impl_re_i),
    .ex_csr_expl_re_i   (ex_csr_expl_re_i),
    .ex_csr_raddr_i     (ex_csr_raddr_i),
    .wb_valid_i         (wb_valid_i),
    .wb_csr_en_i        (wb_csr_en_i),
    .wb_mret_i          (wb_mret_i),
    .wb_csr_impl_wr_i   (wb_csr_impl_wr_i),
    .wb_csr_expl_we_i   (wb_csr_expl_we_i),
    .wb_csr_waddr_i     (wb_csr_waddr_i),
    .csr_stall_id_o     (csr_stall_id_o),
    .csr_stall_ex_o     (csr_stall_ex_o)
  );

endmodule

`default_nettype wire

// File: include/tb_checks.svh
// Testbench reference model
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////
// Random source
//////////////////////////////

// LCG state, fixed seed
logic [31:0] rng_state = 32'h14a2_f80f;

// Low bits of this LCG repeat quickly, callers use the top bits
function automatic logic [31:0] next_random();
  rng_state = rng_state * 32'd1664525 + 32'd1013904223;
  return rng_state;
endfunction

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_fw_sel(input string what, input byp_pkg::fw_sel_e got,
                            input byp_pkg::fw_sel_e exp);
  check_count++;
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    stop_on_failure();
  end
endtask

task automatic check_jalr_sel(input string what, input byp_pkg::jalr_fw_sel_e got,
                              input byp_pkg::jalr_fw_sel_e exp);
  check_count++;
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    stop_on_failure();
  end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    stop_on_failure();
  end
endtask

//////////////////////////////
// Reference model
//////////////////////////////

// Source hits a destination, x0 never counts
function automatic logic dest_hit(input logic re, input pipe_pkg::rf_addr_t src,
                                  input pipe_pkg::rf_addr_t dst);
  return re && (src != '0) && (src == dst);
endfunction

// Youngest live writer supplies the operand
function automatic byp_pkg::fw_sel_e operand_source(input logic re,
                                                    input pipe_pkg::rf_addr_t src);
  if (ex_valid_i && ex_rf_we_i && dest_hit(re, src, ex_waddr_i)) begin
    return byp_pkg::SEL_FW_EX;
  end
  if (wb_valid_i && wb_rf_we_i && dest_hit(re, src, wb_waddr_i)) begin
    return byp_pkg::SEL_FW_WB;
  end
  return byp_pkg::SEL_REGFILE;
endfunction

// Jump target takes WB results only, read enable not needed
function automatic byp_pkg::jalr_fw_sel_e jump_source();
  if (wb_valid_i && wb_rf_we_i && dest_hit(1'b1, id_raddr_a_i, wb_waddr_i)) begin
    return byp_pkg::SELJ_FW_WB;
  end
  return byp_pkg::SELJ_REGFILE;
endfunction

function automatic logic load_hazard();
  logic ex_load;
  logic wb_wait;
  ex_load = ex_valid_i && ex_rf_we_i && ex_lsu_en_i &&
            (dest_hit(id_rf_re_i[0], id_raddr_a_i, ex_waddr_i) ||
             dest_hit(id_rf_re_i[1], id_raddr_b_i, ex_waddr_i));
  wb_wait = !wb_ready_i && wb_valid_i && wb_rf_we_i &&
            (dest_hit(id_rf_re_i[0], id_raddr_a_i, wb_waddr_i) ||
             dest_hit(id_rf_re_i[1], id_raddr_b_i, wb_waddr_i));
  return ex_load || wb_wait;
endfunction

function automatic logic jump_hazard();
  logic ex_dep;
  logic wb_load_dep;
  ex_dep = ex_valid_i && ex_rf_we_i && dest_hit(1'b1, id_raddr_a_i, ex_waddr_i);
  wb_load_dep = wb_valid_i && wb_rf_we_i && wb_lsu_en_i &&
                dest_hit(1'b1, id_raddr_a_i, wb_waddr_i);
  return id_valid_i && id_jalr_i && (ex_dep || wb_load_dep);
endfunction

function automatic logic csr_id_hazard();
  logic ex_writes;
  logic wb_writes;
  ex_writes = ex_valid_i && (ex_csr_en_i || ex_mret_i);
  wb_writes = wb_valid_i && (wb_csr_en_i || wb_mret_i);
  return id_valid_i && (id_mret_i || id_tbljmp_i) && (ex_writes || wb_writes);
endfunction

function automatic logic csr_ex_hazard();
  logic ex_csr;
  logic wb_csr;
  logic wb_implicit;
  logic same_csr;
  ex_csr = ex_valid_i && ex_csr_en_i;
  wb_csr = wb_valid_i && wb_csr_en_i;
  wb_implicit = wb_valid_i && (wb_mret_i || (wb_csr_en_i && wb_csr_impl_wr_i));
  same_csr = ex_csr_expl_re_i && wb_csr_expl_we_i && (ex_csr_raddr_i == wb_csr_waddr_i);
  if (ex_csr && ex_csr_impl_re_i && (wb_csr || wb_implicit)) begin
    return 1'b1;
  end
  return (ex_csr && wb_implicit) || (ex_csr && wb_csr && same_csr);
endfunction

// All nine outputs against the model
task automatic check_against_reference(input string ctx);
  check_fw_sel({ctx, " op_a_fw_sel"}, op_a_fw_sel_o, operand_source(id_rf_re_i[0], id_raddr_a_i));
  check_fw_sel({ctx, " op_b_fw_sel"}, op_b_fw_sel_o, operand_source(id_rf_re_i[1], id_raddr_b_i));
  check_jalr_sel({ctx, " jalr_fw_sel"}, jalr_fw_sel_o, jump_source());
  check_flag({ctx, " load_stall"}, load_stall_o, load_hazard());
  check_flag({ctx, " jalr_stall"}, jalr_stall_o, jump_hazard());
  check_flag({ctx, " csr_stall_id"}, csr_stall_id_o, csr_id_hazard());
  check_flag({ctx, " csr_stall_ex"}, csr_stall_ex_o, csr_ex_hazard());
  check_flag({ctx, " sleep_stall"}, sleep_stall_o, ex_valid_i && ex_wfi_i);
  check_flag({ctx, " deassert_we"}, deassert_we_o, id_fetch_err_i || id_trigger_i);
endtask

`endif

// File: tests/hazard_bypass_tb.sv
// Hazard bypass testbench
`timescale 1ns/1ps
`default_nettype none

module hazard_bypass_tb;

  localparam int HALF_PERIOD_NS = 50;
  localparam int RESET_CYCLES = 5;
  localparam int SETTLE_NS = 10;
  localparam int EDGE_TIMEOUT_STEPS = 250;
  localparam int RANDOM_VECTORS = 200;

  logic clk_i;
  logic rst_i;

  // ID stage
  logic id_valid_i;
  pipe_pkg::rf_re_t id_rf_re_i;
  pipe_pkg::rf_addr_t id_raddr_a_i;
  pipe_pkg::rf_addr_t id_raddr_b_i;
  logic id_jalr_i;
  logic id_mret_i;
  logic id_tbljmp_i;
  logic id_fetch_err_i;
  logic id_trigger_i;

  // EX stage
  logic ex_valid_i;
  logic ex_rf_we_i;
  pipe_pkg::rf_addr_t ex_waddr_i;
  logic ex_lsu_en_i;
  logic ex_csr_en_i;
  logic ex_mret_i;
  logic ex_wfi_i;
  logic ex_csr_impl_wr_i;
  logic ex_csr_impl_re_i;
  logic ex_csr_expl_re_i;
  pipe_pkg::csr_addr_t ex_csr_raddr_i;

  // WB stage
  logic wb_valid_i;
  logic wb_ready_i;
  logic wb_rf_we_i;
  pipe_pkg::rf_addr_t wb_waddr_i;
  logic wb_lsu_en_i;
  logic wb_csr_en_i;
  logic wb_mret_i;
  logic wb_csr_impl_wr_i;
  logic wb_csr_expl_we_i;
  pipe_pkg::csr_addr_t wb_csr_waddr_i;

  // DUT outputs
  byp_pkg::fw_sel_e op_a_fw_sel_o;
  byp_pkg::fw_sel_e op_b_fw_sel_o;
  byp_pkg::jalr_fw_sel_e jalr_fw_sel_o;
  logic load_stall_o;
  logic jalr_stall_o;
  logic csr_stall_id_o;
  logic csr_stall_ex_o;
  logic sleep_stall_o;
  logic deassert_we_o;

  int check_count = 0;

  hazard_bypass_top hazard_bypass_top_inst (.*);

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever begin
      #HALF_PERIOD_NS clk_i = ~clk_i;
    end
  end

  task automatic stop_on_failure();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  `include "tb_checks.svh"

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Returns 1 ns after the next rising edge
  // Polls on half nanoseconds so no poll shares a step with a clock toggle
  task automatic wait_rising_edge();
    int steps;
    steps = 0;
    #0.5;
    while (clk_i !== 1'b0 && steps < EDGE_TIMEOUT_STEPS) begin
      #1;
      steps++;
    end
    while (clk_i !== 1'b1 && steps < EDGE_TIMEOUT_STEPS) begin
      #1;
      steps++;
    end
    if (steps >= EDGE_TIMEOUT_STEPS) begin
      $display("Timeout: no rising clock edge after %0d polls", steps);
      stop_on_failure();
    end else begin
      #0.5;
    end
  endtask

  task automatic drive_idle();
    id_valid_i = 1'b0;
    id_rf_re_i = '0;
    id_raddr_a_i = '0;
    id_raddr_b_i = '0;
    id_jalr_i = 1'b0;
    id_mret_i = 1'b0;
    id_tbljmp_i = 1'b0;
    id_fetch_err_i = 1'b0;
    id_trigger_i = 1'b0;
    ex_valid_i = 1'b0;
    ex_rf_we_i = 1'b0;
    ex_waddr_i = '0;
    ex_lsu_en_i = 1'b0;
    ex_csr_en_i = 1'b0;
    ex_mret_i = 1'b0;
    ex_wfi_i = 1'b0;
    ex_csr_impl_wr_i = 1'b0;
    ex_csr_impl_re_i = 1'b0;
    ex_csr_expl_re_i = 1'b0;
    ex_csr_raddr_i = '0;
    wb_valid_i = 1'b0;
    wb_ready_i = 1'b0;
    wb_rf_we_i = 1'b0;
    wb_waddr_i = '0;
    wb_lsu_en_i = 1'b0;
    wb_csr_en_i = 1'b0;
    wb_mret_i = 1'b0;
    wb_csr_impl_wr_i = 1'b0;
    wb_csr_expl_we_i = 1'b0;
    wb_csr_waddr_i = '0;
  endtask

  // New vector on an otherwise empty pipeline, WB not waiting
  task automatic begin_vector();
    wait_rising_edge();
    drive_idle();
    wb_ready_i = 1'b1;
  endtask

  task automatic settle();
    #SETTLE_NS;
  endtask

  task automatic set_id_reads(input pipe_pkg::rf_re_t re, input pipe_pkg::rf_addr_t a,
                              input pipe_pkg::rf_addr_t b);
    id_valid_i = 1'b1;
    id_rf_re_i = re;
    id_raddr_a_i = a;
    id_raddr_b_i = b;
  endtask

  task automatic set_ex_writer(input logic lsu, input pipe_pkg::rf_addr_t waddr);
    ex_valid_i = 1'b1;
    ex_rf_we_i = 1'b1;
    ex_lsu_en_i = lsu;
    ex_waddr_i = waddr;
  endtask

  task automatic set_wb_writer(input logic lsu, input pipe_pkg::rf_addr_t waddr);
    wb_valid_i = 1'b1;
    wb_rf_we_i = 1'b1;
    wb_lsu_en_i = lsu;
    wb_waddr_i = waddr;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_forwarding();
    // Both stages write x5, EX is younger
    begin_vector();
    set_id_reads(2'b01, 5'd5, 5'd0);
    set_ex_writer(1'b0, 5'd5);
    set_wb_writer(1'b0, 5'd5);
    settle();
    check_fw_sel("both stages op_a", op_a_fw_sel_o, byp_pkg::SEL_FW_EX);
    check_fw_sel("both stages op_b", op_b_fw_sel_o, byp_pkg::SEL_REGFILE);
    // Only WB holds x5
    begin_vector();
    set_id_reads(2'b01, 5'd5, 5'd0);
    set_ex_writer(1'b0, 5'd6);
    set_wb_writer(1'b0, 5'd5);
    settle();
    check_fw_sel("wb only op_a", op_a_fw_sel_o, byp_pkg::SEL_FW_WB);
    // EX bubble with a matching address
    begin_vector();
    set_id_reads(2'b01, 5'd5, 5'd0);
    set_ex_writer(1'b0, 5'd5);
    ex_valid_i = 1'b0;
    set_wb_writer(1'b0, 5'd5);
    settle();
    check_fw_sel("ex bubble op_a", op_a_fw_sel_o, byp_pkg::SEL_FW_WB);
    // x0 on both ports
    begin_vector();
    set_id_reads(2'b11, 5'd0, 5'd0);
    set_ex_writer(1'b0, 5'd0);
    set_wb_writer(1'b0, 5'd0);
    settle();
    check_fw_sel("x0 op_a", op_a_fw_sel_o, byp_pkg::SEL_REGFILE);
    check_fw_sel("x0 op_b", op_b_fw_sel_o, byp_pkg::SEL_REGFILE);
    // Read ports disabled
    begin_vector();
    set_id_reads(2'b00, 5'd5, 5'd5);
    set_ex_writer(1'b0, 5'd5);
    settle();
    check_fw_sel("no read op_a", op_a_fw_sel_o, byp_pkg::SEL_REGFILE);
    check_fw_sel("no read op_b", op_b_fw_sel_o, byp_pkg::SEL_REGFILE);
    // Ports pick their sources independently
    begin_vector();
    set_id_reads(2'b11, 5'd3, 5'd7);
    set_ex_writer(1'b0, 5'd7);
    set_wb_writer(1'b0, 5'd3);
    settle();
    check_fw_sel("split op_a", op_a_fw_sel_o, byp_pkg::SEL_FW_WB);
    check_fw_sel("split op_b", op_b_fw_sel_o, byp_pkg::SEL_FW_EX);
  endtask

  task automatic test_load_stall();
    begin_vector();
    set_id_reads(2'b10, 5'd0, 5'd9);
    set_ex_writer(1'b1, 5'd9);
    settle();
    check_flag("ex load", load_stall_o, 1'b1);
    // ALU result forwards without a stall
    begin_vector();
    set_id_reads(2'b10, 5'd0, 5'd9);
    set_ex_writer(1'b0, 5'd9);
    settle();
    check_flag("ex alu", load_stall_o, 1'b0);
    begin_vector();
    set_id_reads(2'b01, 5'd9, 5'd0);
    set_wb_writer(1'b1, 5'd9);
    settle();
    check_flag("wb ready", load_stall_o, 1'b0);
    // WB waiting on the bus
    begin_vector();
    set_id_reads(2'b01, 5'd9, 5'd0);
    set_wb_writer(1'b1, 5'd9);
    wb_ready_i = 1'b0;
    settle();
    check_flag("wb waiting", load_stall_o, 1'b1);
  endtask

  task automatic test_jump_register();
    begin_vector();
    set_id_reads(2'b01, 5'd1, 5'd0);
    id_jalr_i = 1'b1;
    set_ex_writer(1'b0, 5'd1);
    settle();
    check_flag("jalr ex writer", jalr_stall_o, 1'b1);
    check_jalr_sel("jalr ex writer", jalr_fw_sel_o, byp_pkg::SELJ_REGFILE);
    begin_vector();
    set_id_reads(2'b01, 5'd1, 5'd0);
    id_jalr_i = 1'b1;
    set_wb_writer(1'b1, 5'd1);
    settle();
    check_flag("jalr wb load", jalr_stall_o, 1'b1);
    // ALU result in WB goes straight to the jump target
    begin_vector();
    set_id_reads(2'b01, 5'd1, 5'd0);
    id_jalr_i = 1'b1;
    set_wb_writer(1'b0, 5'd1);
    settle();
    check_flag("jalr wb alu", jalr_stall_o, 1'b0);
    check_jalr_sel("jalr wb alu", jalr_fw_sel_o, byp_pkg::SELJ_FW_WB);
    // No jump in ID, or ID empty
    begin_vector();
    set_id_reads(2'b01, 5'd1, 5'd0);
    set_ex_writer(1'b0, 5'd1);
    settle();
    check_flag("no jalr", jalr_stall_o, 1'b0);
    wait_rising_edge();
    id_jalr_i = 1'b1;
    id_valid_i = 1'b0;
    settle();
    check_flag("jalr id empty", jalr_stall_o, 1'b0);
  endtask

  task automatic test_csr_stalls();
    begin_vector();
    id_valid_i = 1'b1;
    id_mret_i = 1'b1;
    ex_valid_i = 1'b1;
    ex_csr_en_i = 1'b1;
    settle();
    check_flag("mret vs ex csr", csr_stall_id_o, 1'b1);
    begin_vector();
    id_valid_i = 1'b1;
    id_tbljmp_i = 1'b1;
    wb_valid_i = 1'b1;
    wb_mret_i = 1'b1;
    settle();
    check_flag("tbljmp vs wb mret", csr_stall_id_o, 1'b1);
    // Empty EX and WB
    begin_vector();
    id_valid_i = 1'b1;
    id_mret_i = 1'b1;
    settle();
    check_flag("mret alone", csr_stall_id_o, 1'b0);
    // Explicit read after explicit write
    begin_vector();
    ex_valid_i = 1'b1;
    ex_csr_en_i = 1'b1;
    ex_csr_expl_re_i = 1'b1;
    ex_csr_raddr_i = 12'h300;
    wb_valid_i = 1'b1;
    wb_csr_en_i = 1'b1;
    wb_csr_expl_we_i = 1'b1;
    wb_csr_waddr_i = 12'h300;
    settle();
    check_flag("same csr", csr_stall_ex_o, 1'b1);
    wait_rising_edge();
    wb_csr_waddr_i = 12'h305;
    settle();
    check_flag("other csr", csr_stall_ex_o, 1'b0);
    // Implicit WB write behind an explicit CSR op
    begin_vector();
    ex_valid_i = 1'b1;
    ex_csr_en_i = 1'b1;
    wb_valid_i = 1'b1;
    wb_mret_i = 1'b1;
    settle();
    check_flag("wb implicit write", csr_stall_ex_o, 1'b1);
    // Implicit EX read against an unrelated WB write
    begin_vector();
    ex_valid_i = 1'b1;
    ex_csr_en_i = 1'b1;
    ex_csr_impl_re_i = 1'b1;
    ex_csr_raddr_i = 12'h300;
    wb_valid_i = 1'b1;
    wb_csr_en_i = 1'b1;
    wb_csr_waddr_i = 12'h341;
    settle();
    check_flag("ex implicit read", csr_stall_ex_o, 1'b1);
  endtask

  task automatic test_sleep_and_deassert();
    begin_vector();
    ex_wfi_i = 1'b1;
    settle();
    check_flag("wfi ex empty", sleep_stall_o, 1'b0);
    wait_rising_edge();
    ex_valid_i = 1'b1;
    settle();
    check_flag("wfi ex valid", sleep_stall_o, 1'b1);
    begin_vector();
    settle();
    check_flag("clean fetch", deassert_we_o, 1'b0);
    wait_rising_edge();
    id_fetch_err_i = 1'b1;
    settle();
    check_flag("fetch error", deassert_we_o, 1'b1);
    wait_rising_edge();
    id_fetch_err_i = 1'b0;
    id_trigger_i = 1'b1;
    settle();
    check_flag("trigger", deassert_we_o, 1'b1);
  endtask

  // Small address ranges so hits are common
  task automatic test_random();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    for (int n = 0; n < RANDOM_VECTORS; n++) begin
      begin_vector();
      r0 = next_random();
      r1 = next_random();
      r2 = next_random();
      id_valid_i = r0[31];
      id_rf_re_i = r0[30:29];
      id_jalr_i = r0[28];
      id_mret_i = r0[27];
      id_tbljmp_i = r0[26];
      id_fetch_err_i = r0[25];
      id_trigger_i = r0[24];
      id_raddr_a_i = {2'b00, r0[23:21]};
      id_raddr_b_i = {2'b00, r0[20:18]};
      ex_valid_i = r1[31];
      ex_rf_we_i = r1[30];
      ex_lsu_en_i = r1[29];
      ex_csr_en_i = r1[28];
      ex_mret_i = r1[27];
      ex_wfi_i = r1[26];
      ex_csr_impl_wr_i = r1[25];
      ex_csr_impl_re_i = r1[24];
      ex_csr_expl_re_i = r1[23];
      ex_waddr_i = {2'b00, r1[22:20]};
      ex_csr_raddr_i = {11'h180, r1[19]};
      wb_valid_i = r2[31];
      wb_ready_i = r2[30];
      wb_rf_we_i = r2[29];
      wb_lsu_en_i = r2[28];
      wb_csr_en_i = r2[27];
      wb_mret_i = r2[26];
      wb_csr_impl_wr_i = r2[25];
      wb_csr_expl_we_i = r2[24];
      wb_waddr_i = {2'b00, r2[23:21]};
      wb_csr_waddr_i = {11'h180, r2[20]};
      settle();
      check_against_reference($sformatf("random %0d", n));
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    drive_idle();
    rst_i = 1'b1;
    repeat (RESET_CYCLES) begin
      wait_rising_edge();
    end
    // Empty pipeline gives no stall and no forward
    check_against_reference("reset");
    rst_i = 1'b0;
    test_forwarding();
    test_load_stall();
    test_jump_register();
    test_csr_stalls();
    test_sleep_and_deassert();
    test_random();
    if (check_count > 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("No checks were run");
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

// File: hazard_bypass.f
+incdir+include
verilog/pipe_pkg.sv
verilog/byp_pkg.sv
verilog/stage_qualify.sv
verilog/rf_hazard.sv
verilog/csr_hazard.sv
verilog/hazard_bypass_top.sv
tests/hazard_bypass_tb.sv

// File: build.sh
#!/bin/sh
# Compile and run the hazard bypass testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f hazard_bypass.f --top-module hazard_bypass_tb \
  -Mdir obj_dir -o hazard_bypass_sim
if [ $? -ne 0 ]; then
  echo "Verilator compilation failed"
  exit 1
fi

output=$(./obj_dir/hazard_bypass_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
